/* hdl/dnoc_flit_pkg.sv */
package dnoc_flit_pkg;

    // one flit on either ingress channel
    localparam int FLIT_W = 256;

    typedef logic [FLIT_W-1:0] flit_t;

    // command kind bits of a control flit
    localparam int BIT_WR_RESP  = 4;
    localparam int BIT_RESP_SEL = 5;
    localparam int BIT_SYNC     = 6;

    // source node of a sync request or a data packet
    localparam int NODE_ID_LO = 7;
    localparam int NODE_ID_HI = 10;

    // overlaps the node id field, read commands use the wider view
    localparam int MC_SCALE_LO = 7;
    localparam int MC_SCALE_HI = 18;

    localparam int BASE0_LO = 19;
    localparam int BASE0_HI = 31;
    localparam int BASE1_LO = 44;
    localparam int BASE1_HI = 56;

    localparam int PP_EN_BIT = 57;
    localparam int PP_NUM_LO = 58;
    localparam int PP_NUM_HI = 68;

    localparam int PING_LEN_LO = 69;
    localparam int PING_LEN_HI = 81;
    localparam int PONG_LEN_LO = 82;
    localparam int PONG_LEN_HI = 94;

    // four 13-bit entries each, entry 0 in the low bits
    localparam int LOOP_GAP_LO = 95;
    localparam int LOOP_GAP_HI = 146;
    localparam int LOOP_LEN_LO = 147;
    localparam int LOOP_LEN_HI = 198;

    localparam int SYNC_TGT_LO = 199;
    localparam int SYNC_TGT_HI = 210;

endpackage

/* hdl/dnoc_cfg_pkg.sv */
package dnoc_cfg_pkg;

    // local RAM word address
    typedef logic [12:0] ram_addr_t;

    // lengths and gaps, counted in RAM words
    typedef logic [12:0] len_t;

    // multicast scale, also used for the sync target
    typedef logic [11:0] scale_t;

    typedef logic [10:0] pp_num_t;

    typedef logic [3:0] node_id_t;

    localparam int NODE_NUM = 16;
    localparam int LOOP_NUM = 4;
    localparam int BASE_NUM = 2;

    // completed packets per node, saturates at all ones
    typedef logic [3:0] sync_cnt_t;

endpackage

/* hdl/dnoc_itf_in_c_channel.sv */
`timescale 1ns/10ps

module dnoc_itf_in_c_channel
    import dnoc_flit_pkg::*, dnoc_cfg_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,

    // control flits from the noc
    input  flit_t                       out_flit,
    input  logic                        out_last,
    input  logic                        out_valid,
    output logic                        out_ready,

    // sync handshake with the sync board
    output logic                        sync_req,
    input  logic                        sync_gnt,
    output node_id_t                    sync_node_id,

    // dma read command
    output logic                        noc_cmd_dma_rd_req,
    input  logic                        noc_cmd_dma_rd_gnt,

    output ram_addr_t [BASE_NUM-1:0]    n_cfg_d_r_ram_base_addr,
    output len_t                        n_cfg_d_r_ping_lenth,
    output len_t                        n_cfg_d_r_pong_lenth,
    output scale_t                      n_cfg_d_r_noc_mc_scale,
    output scale_t                      n_cfg_d_r_sync_target,
    output logic                        n_cfg_d_r_req_sel,
    output logic                        n_cfg_d_r_pingpong_en,
    output pp_num_t                     n_cfg_d_r_pingpong_num,
    output len_t [LOOP_NUM-1:0]         n_cfg_d_r_loop_lenth,
    output len_t [LOOP_NUM-1:0]         n_cfg_d_r_loop_gap,

    // response pulses
    output logic                        noc_in_dma_rd_response,
    output logic                        noc_in_core_wr_response
);

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        RD_REQ  = 2'd1,
        WR_RESP = 2'd2,
        SYNC    = 2'd3
    } state_t;

    state_t cs;
    state_t ns;
    flit_t  flit_reg;

    // commands are single-flit, decode happens on the tail flit
    logic   take_cmd;

    assign take_cmd = out_valid && out_last;

    always_comb begin
        ns                      = cs;
        out_ready               = 1'b0;
        sync_req                = 1'b0;
        noc_cmd_dma_rd_req      = 1'b0;
        noc_in_dma_rd_response  = 1'b0;
        noc_in_core_wr_response = 1'b0;

        case (cs)
            IDLE: begin
                out_ready = 1'b1;
                if (take_cmd) begin
                    // response wins over sync, read is the default
                    if (out_flit[BIT_WR_RESP]) begin
                        ns = WR_RESP;
                    end else if (out_flit[BIT_SYNC]) begin
                        ns = SYNC;
                    end else begin
                        ns = RD_REQ;
                    end
                end
            end
            RD_REQ: begin
                noc_cmd_dma_rd_req = 1'b1;
                if (noc_cmd_dma_rd_gnt) begin
                    ns = IDLE;
                end
            end
            WR_RESP: begin
                ns = IDLE;
                if (flit_reg[BIT_RESP_SEL]) begin
                    noc_in_dma_rd_response = 1'b1;
                end else begin
                    noc_in_core_wr_response = 1'b1;
                end
            end
            SYNC: begin
                sync_req = 1'b1;
                if (sync_gnt) begin
                    ns = IDLE;
                end
            end
            default: begin
                ns = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs <= IDLE;
        end else begin
            cs <= ns;
        end
    end

    // a stalled sender holds its flit, so this stays steady in service
    always_ff @(posedge clk) begin
        if (out_valid) begin
            flit_reg <= out_flit;
        end
    end

    assign sync_node_id = flit_reg[NODE_ID_HI:NODE_ID_LO];

    // read configuration sliced from the held command
    assign n_cfg_d_r_ram_base_addr[0] = flit_reg[BASE0_HI:BASE0_LO];
    assign n_cfg_d_r_ram_base_addr[1] = flit_reg[BASE1_HI:BASE1_LO];
    assign n_cfg_d_r_ping_lenth       = flit_reg[PING_LEN_HI:PING_LEN_LO];
    assign n_cfg_d_r_pong_lenth       = flit_reg[PONG_LEN_HI:PONG_LEN_LO];
    assign n_cfg_d_r_pingpong_num     = flit_reg[PP_NUM_HI:PP_NUM_LO];
    assign n_cfg_d_r_pingpong_en      = flit_reg[PP_EN_BIT];
    assign n_cfg_d_r_noc_mc_scale     = flit_reg[MC_SCALE_HI:MC_SCALE_LO];
    assign n_cfg_d_r_sync_target      = flit_reg[SYNC_TGT_HI:SYNC_TGT_LO];
    // read requested by the core or by the dma
    assign n_cfg_d_r_req_sel          = flit_reg[BIT_RESP_SEL];
    assign n_cfg_d_r_loop_lenth       = flit_reg[LOOP_LEN_HI:LOOP_LEN_LO];
    assign n_cfg_d_r_loop_gap         = flit_reg[LOOP_GAP_HI:LOOP_GAP_LO];

endmodule

/* hdl/dnoc_itf_in_d_channel.sv */
`timescale 1ns/10ps

module dnoc_itf_in_d_channel
    import dnoc_flit_pkg::*, dnoc_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // data packets from the noc
    input  flit_t       d_flit,
    input  logic        d_last,
    input  logic        d_valid,
    output logic        d_ready,

    // local ram write port
    output logic        ram_we,
    output ram_addr_t   ram_waddr,
    output flit_t       ram_wdata,

    // completion report to the sync board
    output logic        pkt_done,
    output node_id_t    pkt_node_id
);

    typedef enum logic {
        HEAD = 1'b0,
        BODY = 1'b1
    } state_t;

    state_t    state;
    ram_addr_t base_addr;
    ram_addr_t beat_cnt;

    // ram takes a word every cycle, never stall the sender
    assign d_ready = 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= HEAD;
            ram_we   <= 1'b0;
            pkt_done <= 1'b0;
        end else begin
            ram_we   <= 1'b0;
            pkt_done <= 1'b0;
            if (d_valid) begin
                case (state)
                    HEAD: begin
                        // header-only packet still counts as done
                        if (d_last) begin
                            pkt_done <= 1'b1;
                        end else begin
                            state <= BODY;
                        end
                    end
                    BODY: begin
                        ram_we <= 1'b1;
                        if (d_last) begin
                            pkt_done <= 1'b1;
                            state    <= HEAD;
                        end
                    end
                    default: begin
                        state <= HEAD;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (d_valid) begin
            if (state == HEAD) begin
                pkt_node_id <= d_flit[NODE_ID_HI:NODE_ID_LO];
                base_addr   <= d_flit[BASE0_HI:BASE0_LO];
                beat_cnt    <= '0;
            end else begin
                ram_waddr <= base_addr + beat_cnt;
                ram_wdata <= d_flit;
                beat_cnt  <= beat_cnt + 1'b1;
            end
        end
    end

endmodule

/* hdl/dnoc_itf_sync_board.sv */
`timescale 1ns/10ps

module dnoc_itf_sync_board
    import dnoc_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // completed packets from the data channel
    input  logic        pkt_done,
    input  node_id_t    pkt_node_id,

    // sync requests from the control channel
    input  logic        sync_req,
    input  node_id_t    sync_node_id,
    output logic        sync_gnt,

    // finished sync report
    output logic        sync_done,
    output node_id_t    sync_done_node
);

    sync_cnt_t cnt [NODE_NUM];
    logic      pkt_hit;

    // a packet landing this cycle can serve the request directly
    assign pkt_hit  = pkt_done && (pkt_node_id == sync_node_id);
    assign sync_gnt = sync_req && ((cnt[sync_node_id] != '0) || pkt_hit);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NODE_NUM; i++) begin
                cnt[i] <= '0;
            end
            sync_done <= 1'b0;
        end else begin
            for (int i = 0; i < NODE_NUM; i++) begin
                // increment and decrement on one node cancel out
                if (pkt_done && (pkt_node_id == node_id_t'(i))) begin
                    if (!(sync_gnt && (sync_node_id == node_id_t'(i)))) begin
                        if (cnt[i] != '1) begin
                            cnt[i] <= cnt[i] + 1'b1;
                        end
                    end
                end else if (sync_gnt && (sync_node_id == node_id_t'(i))) begin
                    cnt[i] <= cnt[i] - 1'b1;
                end
            end
            sync_done <= sync_gnt;
        end
    end

    always_ff @(posedge clk) begin
        if (sync_gnt) begin
            sync_done_node <= sync_node_id;
        end
    end

endmodule

/* hdl/dnoc_itf_in.sv */
`timescale 1ns/10ps

module dnoc_itf_in
    import dnoc_flit_pkg::*, dnoc_cfg_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,

    // control channel
    input  flit_t                       out_flit,
    input  logic                        out_last,
    input  logic                        out_valid,
    output logic                        out_ready,

    // dma read command and configuration
    output logic                        noc_cmd_dma_rd_req,
    input  logic                        noc_cmd_dma_rd_gnt,
    output ram_addr_t [BASE_NUM-1:0]    n_cfg_d_r_ram_base_addr,
    output len_t                        n_cfg_d_r_ping_lenth,
    output len_t                        n_cfg_d_r_pong_lenth,
    output scale_t                      n_cfg_d_r_noc_mc_scale,
    output scale_t                      n_cfg_d_r_sync_target,
    output logic                        n_cfg_d_r_req_sel,
    output logic                        n_cfg_d_r_pingpong_en,
    output pp_num_t                     n_cfg_d_r_pingpong_num,
    output len_t [LOOP_NUM-1:0]         n_cfg_d_r_loop_lenth,
    output len_t [LOOP_NUM-1:0]         n_cfg_d_r_loop_gap,

    output logic                        noc_in_dma_rd_response,
    output logic                        noc_in_core_wr_response,

    // data channel
    input  flit_t                       d_flit,
    input  logic                        d_last,
    input  logic                        d_valid,
    output logic                        d_ready,

    // ram write port
    output logic                        ram_we,
    output ram_addr_t                   ram_waddr,
    output flit_t                       ram_wdata,

    // finished sync
    output logic                        sync_done,
    output node_id_t                    sync_done_node
);

    logic     sync_req;
    logic     sync_gnt;
    node_id_t sync_node_id;
    logic     pkt_done;
    node_id_t pkt_node_id;

    dnoc_itf_in_c_channel u_c_channel (
        .clk                        (clk),
        .rst_n                      (rst_n),
        .out_flit                   (out_flit),
        .out_last                   (out_last),
        .out_valid                  (out_valid),
        .out_ready                  (out_ready),
        .sync_req                   (sync_req),
        .sync_gnt                   (sync_gnt),
        .sync_node_id               (sync_node_id),
        .noc_cmd_dma_rd_req         (noc_cmd_dma_rd_req),
        .noc_cmd_dma_rd_gnt         (noc_cmd_dma_rd_gnt),
        .n_cfg_d_r_ram_base_addr    (n_cfg_d_r_ram_base_addr),
        .n_cfg_d_r_ping_lenth       (n_cfg_d_r_ping_lenth),
        .n_cfg_d_r_pong_lenth       (n_cfg_d_r_pong_lenth),
        .n_cfg_d_r_noc_mc_scale     (n_cfg_d_r_noc_mc_scale),
        .n_cfg_d_r_sync_target      (n_cfg_d_r_sync_target),
        .n_cfg_d_r_req_sel          (n_cfg_d_r_req_sel),
        .n_cfg_d_r_pingpong_en      (n_cfg_d_r_pingpong_en),
        .n_cfg_d_r_pingpong_num     (n_cfg_d_r_pingpong_num),
        .n_cfg_d_r_loop_lenth       (n_cfg_d_r_loop_lenth),
        .n_cfg_d_r_loop_gap         (n_cfg_d_r_loop_gap),
        .noc_in_dma_rd_response     (noc_in_dma_rd_response),
        .noc_in_core_wr_response    (noc_in_core_wr_response)
    );

    dnoc_itf_in_d_channel u_d_channel (
        .clk            (clk),
        .rst_n          (rst_n),
        .d_flit         (d_flit),
        .d_last         (d_last),
        .d_valid        (d_valid),
        .d_ready        (d_ready),
        .ram_we         (ram_we),
        .ram_waddr      (ram_waddr),
        .ram_wdata      (ram_wdata),
        .pkt_done       (pkt_done),
        .pkt_node_id    (pkt_node_id)
    );

    dnoc_itf_sync_board u_sync_board (
        .clk            (clk),
        .rst_n          (rst_n),
        .pkt_done       (pkt_done),
        .pkt_node_id    (pkt_node_id),
        .sync_req       (sync_req),
        .sync_node_id   (sync_node_id),
        .sync_gnt       (sync_gnt),
        .sync_done      (sync_done),
        .sync_done_node (sync_done_node)
    );

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // low over four rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* dv/tb_dnoc_itf_in.sv */
`timescale 1ns/10ps

module tb_dnoc_itf_in
    import dnoc_flit_pkg::*, dnoc_cfg_pkg::*;
();

    localparam logic [2:0] K_RST       = 3'd0;
    localparam logic [2:0] K_RD        = 3'd1;
    localparam logic [2:0] K_RESP      = 3'd2;
    localparam logic [2:0] K_PKT       = 3'd3;
    localparam logic [2:0] K_SYNC_HIT  = 3'd4;
    localparam logic [2:0] K_SYNC_WAIT = 3'd5;

    localparam int NUM_TESTS        = 12;
    localparam int MAX_ENTRY_CYCLES = 40;
    // flit taken at the next edge then granted in SYNC and done one edge later
    localparam int SYNC_LAT         = 2;
    localparam int HOLD_CYCLES      = 4;
    // table length times the worst entry plus reset
    localparam int WATCHDOG_NS      = (NUM_TESTS * MAX_ENTRY_CYCLES + 10) * 100;

    typedef len_t [LOOP_NUM-1:0] loop_t;

    typedef struct packed {
        logic [2:0] kind;
        node_id_t   node;
        ram_addr_t  base;
        logic [3:0] beats;
        logic [3:0] gnt_dly;
        logic       sel;
        logic       exp_done;
    } entry_t;

    logic                       clk;
    logic                       rst_n;
    flit_t                      out_flit;
    logic                       out_last;
    logic                       out_valid;
    logic                       out_ready;
    logic                       noc_cmd_dma_rd_req;
    logic                       noc_cmd_dma_rd_gnt;
    ram_addr_t [BASE_NUM-1:0]   n_cfg_d_r_ram_base_addr;
    len_t                       n_cfg_d_r_ping_lenth;
    len_t                       n_cfg_d_r_pong_lenth;
    scale_t                     n_cfg_d_r_noc_mc_scale;
    scale_t                     n_cfg_d_r_sync_target;
    logic                       n_cfg_d_r_req_sel;
    logic                       n_cfg_d_r_pingpong_en;
    pp_num_t                    n_cfg_d_r_pingpong_num;
    loop_t                      n_cfg_d_r_loop_lenth;
    loop_t                      n_cfg_d_r_loop_gap;
    logic                       noc_in_dma_rd_response;
    logic                       noc_in_core_wr_response;
    flit_t                      d_flit;
    logic                       d_last;
    logic                       d_valid;
    logic                       d_ready;
    logic                       ram_we;
    ram_addr_t                  ram_waddr;
    flit_t                      ram_wdata;
    logic                       sync_done;
    node_id_t                   sync_done_node;

    // fields of the read command in flight
    ram_addr_t  exp_base0;
    ram_addr_t  exp_base1;
    len_t       exp_ping;
    len_t       exp_pong;
    scale_t     exp_scale;
    scale_t     exp_tgt;
    pp_num_t    exp_ppn;
    logic       exp_pp_en;
    loop_t      exp_loop_len;
    loop_t      exp_loop_gap;

    int         errors;
    int         failed_tests;
    int         err_before;
    int         dma_seen;
    int         core_seen;
    int         done_seen;
    node_id_t   done_node;
    entry_t     tests [NUM_TESTS];
    string      kind_name [6] = '{"reset", "read command", "response", "data packet",
                                  "sync ready", "sync pending"};

    tb_clk_gen u_clk_gen (
        .clk    (clk),
        .rst_n  (rst_n)
    );

    dnoc_itf_in UUT (.*);

    // all sampling happens here, on the falling edge
    task automatic next_cycle();
        @(negedge clk);
        if (noc_in_dma_rd_response) begin
            dma_seen++;
        end
        if (noc_in_core_wr_response) begin
            core_seen++;
        end
        if (sync_done) begin
            done_seen++;
            done_node = sync_done_node;
        end
    endtask

    task automatic check_eq(input logic [FLIT_W-1:0] got, input logic [FLIT_W-1:0] exp,
                            input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic flit_t rand_flit();
        flit_t f;
        for (int i = 0; i < FLIT_W / 32; i++) begin
            f[i*32 +: 32] = $urandom();
        end
        return f;
    endfunction

    // single-flit command withdrawn after the accepting edge
    task automatic send_cmd(input flit_t f);
        check_eq(out_ready, 1'b1, "out_ready before command");
        out_flit  = f;
        out_valid = 1'b1;
        out_last  = 1'b1;
        next_cycle();
        out_valid = 1'b0;
        out_last  = 1'b0;
        // idle bus data must leave the command in service untouched
        out_flit  = rand_flit();
    endtask

    task automatic check_cfg();
        check_eq(n_cfg_d_r_ram_base_addr[0], exp_base0, "base address 0");
        check_eq(n_cfg_d_r_ram_base_addr[1], exp_base1, "base address 1");
        check_eq(n_cfg_d_r_ping_lenth, exp_ping, "ping length");
        check_eq(n_cfg_d_r_pong_lenth, exp_pong, "pong length");
        check_eq(n_cfg_d_r_noc_mc_scale, exp_scale, "multicast scale");
        check_eq(n_cfg_d_r_sync_target, exp_tgt, "sync target");
        check_eq(n_cfg_d_r_pingpong_num, exp_ppn, "ping-pong count");
        check_eq(n_cfg_d_r_pingpong_en, exp_pp_en, "ping-pong enable");
        check_eq(n_cfg_d_r_loop_lenth, exp_loop_len, "loop lengths");
        check_eq(n_cfg_d_r_loop_gap, exp_loop_gap, "loop gaps");
    endtask

    task automatic run_read(input entry_t e);
        flit_t f;
        exp_base0    = ram_addr_t'($urandom());
        exp_base1    = ram_addr_t'($urandom());
        exp_ping     = len_t'($urandom());
        exp_pong     = len_t'($urandom());
        exp_scale    = scale_t'($urandom());
        exp_tgt      = scale_t'($urandom());
        exp_ppn      = pp_num_t'($urandom());
        exp_pp_en    = 1'($urandom());
        exp_loop_len = loop_t'({$urandom(), $urandom()});
        exp_loop_gap = loop_t'({$urandom(), $urandom()});
        f = rand_flit();
        f[BASE0_HI:BASE0_LO]       = exp_base0;
        f[BASE1_HI:BASE1_LO]       = exp_base1;
        f[PING_LEN_HI:PING_LEN_LO] = exp_ping;
        f[PONG_LEN_HI:PONG_LEN_LO] = exp_pong;
        f[MC_SCALE_HI:MC_SCALE_LO] = exp_scale;
        f[SYNC_TGT_HI:SYNC_TGT_LO] = exp_tgt;
        f[PP_NUM_HI:PP_NUM_LO]     = exp_ppn;
        f[PP_EN_BIT]               = exp_pp_en;
        f[LOOP_LEN_HI:LOOP_LEN_LO] = exp_loop_len;
        f[LOOP_GAP_HI:LOOP_GAP_LO] = exp_loop_gap;
        f[BIT_WR_RESP]             = 1'b0;
        f[BIT_SYNC]                = 1'b0;
        f[BIT_RESP_SEL]            = e.sel;
        send_cmd(f);
        check_eq(noc_cmd_dma_rd_req, 1'b1, "dma read request raised");
        check_eq(out_ready, 1'b0, "out_ready low in service");
        check_eq(n_cfg_d_r_req_sel, e.sel, "request select");
        check_cfg();
        repeat (e.gnt_dly) begin
            next_cycle();
            check_eq(noc_cmd_dma_rd_req, 1'b1, "dma read request held");
            check_eq(out_ready, 1'b0, "out_ready low until grant");
        end
        check_cfg();
        noc_cmd_dma_rd_gnt = 1'b1;
        next_cycle();
        noc_cmd_dma_rd_gnt = 1'b0;
        check_eq(noc_cmd_dma_rd_req, 1'b0, "dma read request after grant");
        check_eq(out_ready, 1'b1, "out_ready after grant");
    endtask

    task automatic run_resp(input entry_t e);
        flit_t f;
        f = rand_flit();
        f[BIT_WR_RESP]  = 1'b1;
        f[BIT_RESP_SEL] = e.sel;
        send_cmd(f);
        repeat (2) next_cycle();
        check_eq(dma_seen, e.sel, "dma read response pulses");
        check_eq(core_seen, !e.sel, "core write response pulses");
        check_eq(out_ready, 1'b1, "out_ready after response");
    endtask

    task automatic run_sync(input entry_t e);
        flit_t f;
        int    lat;
        f = rand_flit();
        f[BIT_WR_RESP]             = 1'b0;
        f[BIT_SYNC]                = 1'b1;
        f[NODE_ID_HI:NODE_ID_LO]   = e.node;
        send_cmd(f);
        if (e.kind == K_SYNC_HIT) begin
            lat = 1;
            while (done_seen == 0 && lat < MAX_ENTRY_CYCLES) begin
                next_cycle();
                lat++;
            end
            check_eq(done_seen, 1, "sync_done count");
            check_eq(lat, SYNC_LAT, "sync_done latency");
            check_eq(done_node, e.node, "sync_done node");
            check_eq(out_ready, 1'b1, "out_ready after sync");
        end else begin
            repeat (HOLD_CYCLES) next_cycle();
            check_eq(out_ready, 1'b0, "out_ready held by pending sync");
            check_eq(done_seen, 0, "no sync_done before packet");
        end
    endtask

    task automatic send_packet(input entry_t e);
        flit_t data [$];
        flit_t hdr;
        for (int k = 0; k < e.beats; k++) begin
            data.push_back(rand_flit());
        end
        hdr = rand_flit();
        hdr[NODE_ID_HI:NODE_ID_LO] = e.node;
        hdr[BASE0_HI:BASE0_LO]     = e.base;
        // each data beat shows up on the write port one falling edge after it is driven
        for (int i = 0; i <= e.beats + 1; i++) begin
            if (i >= 2) begin
                check_eq(ram_we, 1'b1, "ram_we on data beat");
                check_eq(ram_waddr, ram_addr_t'(e.base + i - 2), "ram write address");
                check_eq(ram_wdata, data[i-2], "ram write data");
            end else begin
                check_eq(ram_we, 1'b0, "no ram write for header");
            end
            if (i == 0) begin
                d_flit  = hdr;
                d_valid = 1'b1;
                d_last  = 1'b0;
            end else if (i <= e.beats) begin
                d_flit = data[i-1];
                d_last = (i == e.beats);
            end else begin
                d_valid = 1'b0;
                d_last  = 1'b0;
            end
            next_cycle();
        end
        check_eq(ram_we, 1'b0, "no ram write after packet");
        next_cycle();
        check_eq(done_seen, e.exp_done, "sync_done after packet");
        if (e.exp_done) begin
            check_eq(done_node, e.node, "sync_done node after packet");
            check_eq(out_ready, 1'b1, "out_ready after released sync");
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        out_flit           = '0;
        out_last           = 1'b0;
        out_valid          = 1'b0;
        noc_cmd_dma_rd_gnt = 1'b0;
        d_flit             = '0;
        d_last             = 1'b0;
        d_valid            = 1'b0;
        errors             = 0;
        failed_tests       = 0;
        done_node          = '0;
        void'($urandom(32'h61b7));

        // kind, node, base, beats, grant delay, select, sync_done expected
        tests[0]  = '{K_RST, 4'd0, 13'h0000, 4'd0, 4'd0, 1'b0, 1'b0};
        tests[1]  = '{K_RD, 4'd0, 13'h0000, 4'd0, 4'd3, 1'b0, 1'b0};
        tests[2]  = '{K_RD, 4'd0, 13'h0000, 4'd0, 4'd0, 1'b1, 1'b0};
        tests[3]  = '{K_RESP, 4'd0, 13'h0000, 4'd0, 4'd0, 1'b1, 1'b0};
        tests[4]  = '{K_RESP, 4'd0, 13'h0000, 4'd0, 4'd0, 1'b0, 1'b0};
        tests[5]  = '{K_PKT, 4'd3, 13'h0100, 4'd4, 4'd0, 1'b0, 1'b0};
        tests[6]  = '{K_SYNC_HIT, 4'd3, 13'h0000, 4'd0, 4'd0, 1'b0, 1'b0};
        tests[7]  = '{K_SYNC_WAIT, 4'd9, 13'h0000, 4'd0, 4'd0, 1'b0, 1'b0};
        tests[8]  = '{K_PKT, 4'd9, 13'h1ffe, 4'd3, 4'd0, 1'b0, 1'b1};
        tests[9]  = '{K_SYNC_WAIT, 4'd9, 13'h0000, 4'd0, 4'd0, 1'b0, 1'b0};
        tests[10] = '{K_PKT, 4'd9, 13'h0040, 4'd2, 4'd0, 1'b0, 1'b1};
        tests[11] = '{K_RD, 4'd0, 13'h0000, 4'd0, 4'd7, 1'b1, 1'b0};

        wait (rst_n === 1'b1);
        for (int t = 0; t < NUM_TESTS; t++) begin
            dma_seen   = 0;
            core_seen  = 0;
            done_seen  = 0;
            err_before = errors;
            next_cycle();
            case (tests[t].kind)
                K_RST: begin
                    check_eq(out_ready, 1'b1, "out_ready after reset");
                    check_eq(d_ready, 1'b1, "d_ready after reset");
                    check_eq(noc_cmd_dma_rd_req, 1'b0, "dma read request after reset");
                    check_eq(sync_done, 1'b0, "sync_done after reset");
                    check_eq(ram_we, 1'b0, "ram_we after reset");
                    check_eq(noc_in_dma_rd_response, 1'b0, "dma response after reset");
                    check_eq(noc_in_core_wr_response, 1'b0, "core response after reset");
                end
                K_RD:        run_read(tests[t]);
                K_RESP:      run_resp(tests[t]);
                K_PKT:       send_packet(tests[t]);
                default:     run_sync(tests[t]);
            endcase
            if (errors == err_before) begin
                $display("test %0d %s: pass", t, kind_name[tests[t].kind]);
            end else begin
                failed_tests++;
                $display("test %0d %s: fail", t, kind_name[tests[t].kind]);
            end
        end

        $display("%0d tests run, %0d failed, %0d check errors", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* src.f */
hdl/dnoc_flit_pkg.sv
hdl/dnoc_cfg_pkg.sv
hdl/dnoc_itf_in_c_channel.sv
hdl/dnoc_itf_in_d_channel.sv
hdl/dnoc_itf_sync_board.sv
hdl/dnoc_itf_in.sv
dv/tb_clk_gen.sv
dv/tb_dnoc_itf_in.sv

/* Bender.yml */
package:
  name: dnoc_itf_in

sources:
  - hdl/dnoc_flit_pkg.sv
  - hdl/dnoc_cfg_pkg.sv
  - hdl/dnoc_itf_in_c_channel.sv
  - hdl/dnoc_itf_in_d_channel.sv
  - hdl/dnoc_itf_sync_board.sv
  - hdl/dnoc_itf_in.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_dnoc_itf_in.sv
